// File: verilog/elev_cfg_pkg.sv
/* Building size, car count and cycle timing of the elevator bank.
   Every RTL file reads these constants by scoped name. */
package elev_cfg_pkg;

    // ********************
    // Building.
    // ********************

    // Floors are numbered 0 to NUM_FLOORS-1.
    localparam int NUM_FLOORS = 4;
    // Cars are numbered 0 to NUM_CARS-1.
    localparam int NUM_CARS = 2;
    localparam int FLOOR_W = 2;
    localparam int CAR_W = 1;

    // Highest floor, sized like a floor number.
    localparam logic [FLOOR_W-1:0] TOP_FLOOR = FLOOR_W'(NUM_FLOORS - 1);

    // ********************
    // Timing.
    // ********************

    // Cycles from departure to arrival at the adjacent floor.
    localparam int TRAVEL_CYCLES = 6;
    // Cycles spent in each of OPENING, OPEN and CLOSING.
    localparam int DOOR_CYCLES = 3;

    // Timer widths and terminal counts.
    localparam int TRAVEL_W = $clog2(TRAVEL_CYCLES);
    localparam int DOOR_W = $clog2(DOOR_CYCLES);
    localparam logic [TRAVEL_W-1:0] TRAVEL_LAST = TRAVEL_W'(TRAVEL_CYCLES - 1);
    localparam logic [DOOR_W-1:0] DOOR_LAST = DOOR_W'(DOOR_CYCLES - 1);

endpackage

// File: verilog/elev_types_pkg.sv
/* Enumerations and packed structs passed between the hall-call controller,
   the cars, the arrival queue and the pins of the bank. */
package elev_types_pkg;

    // Direction of travel; also the index of the up and down hall buttons.
    typedef enum logic {
        UP   = 1'b0,
        DOWN = 1'b1
    } dir_t;

    typedef enum logic {
        STOPPED = 1'b0,
        MOVING  = 1'b1
    } motion_t;

    // Encoding follows the door cycle, so the next state is the current one plus one.
    typedef enum logic [1:0] {
        CLOSED  = 2'd0,
        OPENING = 2'd1,
        OPEN    = 2'd2,
        CLOSING = 2'd3
    } door_t;

    // Hall button press.
    typedef struct packed {
        logic [elev_cfg_pkg::FLOOR_W-1:0] floor;
        dir_t                             dir;
    } hall_call_t;

    // Cab button press, tagged with the car it belongs to.
    typedef struct packed {
        logic [elev_cfg_pkg::CAR_W-1:0]   car;
        logic [elev_cfg_pkg::FLOOR_W-1:0] floor;
    } car_call_t;

    // Controller command to one car.
    typedef struct packed {
        logic stop_next;
        logic continue_on;
    } car_cmd_t;

    // Car state; arrived is high for one cycle after each arrival.
    typedef struct packed {
        logic [elev_cfg_pkg::FLOOR_W-1:0] floor;
        dir_t                             dir;
        motion_t                          motion;
        door_t                            door;
        logic                             arrived;
    } car_status_t;

    // One arrival report.
    typedef struct packed {
        logic [elev_cfg_pkg::CAR_W-1:0]   car;
        logic [elev_cfg_pkg::FLOOR_W-1:0] floor;
        dir_t                             dir;
    } arrival_event_t;

endpackage

// File: verilog/hall_call_dispatch.sv
/* Hall-call controller. Stores the up and down floor buttons, tells each car
   whether to stop or carry on, and clears the buttons a car has taken. */
module hall_call_dispatch (
    input  logic                                      clk,
    input  logic                                      rst,
    input  elev_types_pkg::hall_call_t                hall_call,
    input  logic                                      hall_valid,
    output logic                                      hall_ready,
    input  elev_types_pkg::car_status_t               status [elev_cfg_pkg::NUM_CARS],
    output elev_types_pkg::car_cmd_t                  cmd [elev_cfg_pkg::NUM_CARS],
    output logic [1:0][elev_cfg_pkg::NUM_FLOORS-1:0]  hall_lamps
);

    // Buttons indexed by dir_t, then floor.
    logic [1:0][elev_cfg_pkg::NUM_FLOORS-1:0] btn;
    // Buttons taken by a car in this cycle.
    logic [1:0][elev_cfg_pkg::NUM_FLOORS-1:0] commit;
    // Buttons still free while cars are served in order.
    logic [1:0][elev_cfg_pkg::NUM_FLOORS-1:0] avail;

    // Buttons are plain flags, so a press is always accepted.
    assign hall_ready = 1'b1;
    assign hall_lamps = btn;

    // ********************
    // Per-car decisions.
    // ********************
    always_comb begin
        int stop_f;
        avail = btn;
        commit = '0;
        // Lower car numbers are served first and mask what they take.
        for (int c = 0; c < elev_cfg_pkg::NUM_CARS; c++) begin
            // A moving car can still stop at the floor it is heading for.
            // A stopped car can only pick up at its own floor.
            stop_f = int'(status[c].floor);
            if (status[c].motion == elev_types_pkg::MOVING) begin
                if (status[c].dir == elev_types_pkg::UP) begin
                    stop_f = stop_f + 1;
                end else begin
                    stop_f = stop_f - 1;
                end
            end
            cmd[c].stop_next = 1'b0;
            if (stop_f >= 0 && stop_f < elev_cfg_pkg::NUM_FLOORS &&
                avail[status[c].dir][stop_f]) begin
                cmd[c].stop_next = 1'b1;
                commit[status[c].dir][stop_f] = 1'b1;
                avail[status[c].dir][stop_f] = 1'b0;
            end

            // Any call strictly beyond the car keeps it going.
            cmd[c].continue_on = 1'b0;
            for (int f = 0; f < elev_cfg_pkg::NUM_FLOORS; f++) begin
                if (status[c].dir == elev_types_pkg::UP) begin
                    if (f > int'(status[c].floor)) begin
                        cmd[c].continue_on = cmd[c].continue_on | btn[0][f] | btn[1][f];
                    end
                end else if (f < int'(status[c].floor)) begin
                    cmd[c].continue_on = cmd[c].continue_on | btn[0][f] | btn[1][f];
                end
            end
        end
    end

    // ********************
    // Button storage.
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            btn <= '0;
        end else begin
            btn <= btn & ~commit;
            // A press on a button being taken is already served.
            if (hall_valid && !commit[hall_call.dir][hall_call.floor]) begin
                btn[hall_call.dir][hall_call.floor] <= 1'b1;
            end
        end
    end

    // A taken button is dark on the very next cycle, whatever the cars do.
    a_commit_clears: assert property (@(posedge clk) disable iff (rst)
        commit != '0 |=> (btn & $past(commit)) == '0);

endmodule

// File: verilog/elevator_car.sv
/* One elevator car. Holds its cab buttons, floor and direction, and runs the
   motion and door state machines on fixed travel and dwell timers. */
module elevator_car #(
    parameter logic [elev_cfg_pkg::CAR_W-1:0] car_id = '0
) (
    input  logic                                clk,
    input  logic                                rst,
    input  elev_types_pkg::car_call_t           car_call,
    input  logic                                car_valid,
    input  elev_types_pkg::car_cmd_t            cmd,
    input  logic                                hold,
    output elev_types_pkg::car_status_t         status,
    output logic [elev_cfg_pkg::NUM_FLOORS-1:0] lamps
);

    logic [elev_cfg_pkg::FLOOR_W-1:0]  floor_q;
    elev_types_pkg::dir_t              dir_q;
    elev_types_pkg::motion_t           motion_q;
    elev_types_pkg::door_t             door_q;
    logic                              arrived_q;
    logic [elev_cfg_pkg::TRAVEL_W-1:0] travel_cnt;
    logic [elev_cfg_pkg::DOOR_W-1:0]   door_cnt;

    logic [elev_cfg_pkg::FLOOR_W-1:0]  next_floor;
    logic [elev_cfg_pkg::FLOOR_W-1:0]  stop_floor;
    logic                              cab_above;
    logic                              cab_below;
    logic                              ahead;
    logic                              door_start;
    logic                              start;

    assign status = '{floor: floor_q, dir: dir_q, motion: motion_q,
                      door: door_q, arrived: arrived_q};

    // Adjacent floor in the current direction.
    assign next_floor = (dir_q == elev_types_pkg::UP) ? floor_q + 1'b1 : floor_q - 1'b1;
    // Floor a stop_next command refers to.
    assign stop_floor = (motion_q == elev_types_pkg::MOVING) ? next_floor : floor_q;

    always_comb begin
        cab_above = 1'b0;
        cab_below = 1'b0;
        for (int f = 0; f < elev_cfg_pkg::NUM_FLOORS; f++) begin
            if (f > int'(floor_q)) begin
                cab_above = cab_above | lamps[f];
            end
            if (f < int'(floor_q)) begin
                cab_below = cab_below | lamps[f];
            end
        end
    end

    // Work remaining in the current direction.
    assign ahead = cmd.continue_on ||
                   (dir_q == elev_types_pkg::UP ? cab_above : cab_below);

    // Lit lamp at the floor of a stopped car opens the door.
    assign door_start = motion_q == elev_types_pkg::STOPPED &&
                        door_q == elev_types_pkg::CLOSED && lamps[floor_q];

    // Departure waits for a closed door, no pending open and a drained report.
    assign start = motion_q == elev_types_pkg::STOPPED &&
                   door_q == elev_types_pkg::CLOSED && !lamps[floor_q] &&
                   !cmd.stop_next && !hold && !arrived_q && ahead;

    // ********************
    // Cab buttons.
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            lamps <= '0;
        end else begin
            if (car_valid && car_call.car == car_id) begin
                lamps[car_call.floor] <= 1'b1;
            end
            // A taken hall call becomes a stop request of this car.
            if (cmd.stop_next) begin
                lamps[stop_floor] <= 1'b1;
            end
            // The opening door serves everything at this floor.
            if (door_start) begin
                lamps[floor_q] <= 1'b0;
            end
        end
    end

    // ********************
    // Motion and travel timer.
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            floor_q <= '0;
            motion_q <= elev_types_pkg::STOPPED;
            travel_cnt <= '0;
            arrived_q <= 1'b0;
        end else begin
            arrived_q <= 1'b0;
            case (motion_q)
                elev_types_pkg::STOPPED: begin
                    if (start) begin
                        motion_q <= elev_types_pkg::MOVING;
                        travel_cnt <= '0;
                    end
                end
                default: begin
                    if (travel_cnt == elev_cfg_pkg::TRAVEL_LAST) begin
                        motion_q <= elev_types_pkg::STOPPED;
                        floor_q <= next_floor;
                        arrived_q <= 1'b1;
                    end else begin
                        travel_cnt <= travel_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // ********************
    // Door and dwell timer.
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            door_q <= elev_types_pkg::CLOSED;
            door_cnt <= '0;
        end else if (door_q == elev_types_pkg::CLOSED) begin
            if (door_start) begin
                door_q <= elev_types_pkg::OPENING;
                door_cnt <= '0;
            end
        end else if (door_cnt == elev_cfg_pkg::DOOR_LAST) begin
            // OPENING, OPEN, CLOSING, then back to CLOSED.
            door_q <= elev_types_pkg::door_t'(door_q + 2'd1);
            door_cnt <= '0;
        end else begin
            door_cnt <= door_cnt + 1'b1;
        end
    end

    // Direction holds while travelling.
    // Reverses when idle ahead; forced at the end floors.
    always_ff @(posedge clk) begin
        if (rst) begin
            dir_q <= elev_types_pkg::UP;
        end else if (motion_q == elev_types_pkg::STOPPED) begin
            if (floor_q == elev_cfg_pkg::TOP_FLOOR) begin
                dir_q <= elev_types_pkg::DOWN;
            end else if (floor_q == '0) begin
                dir_q <= elev_types_pkg::UP;
            end else if (!ahead) begin
                dir_q <= (dir_q == elev_types_pkg::UP) ? elev_types_pkg::DOWN
                                                       : elev_types_pkg::UP;
            end
        end
    end

    a_move_closed: assert property (@(posedge clk) disable iff (rst)
        motion_q == elev_types_pkg::MOVING |-> door_q == elev_types_pkg::CLOSED);

    // Never heads past the top or the bottom floor.
    a_floor_range: assert property (@(posedge clk) disable iff (rst)
        motion_q == elev_types_pkg::MOVING |->
            (dir_q == elev_types_pkg::UP ? floor_q != elev_cfg_pkg::TOP_FLOOR
                                         : floor_q != '0));

endmodule

// File: verilog/arrival_event_queue.sv
/* Arrival-event queue. One pending report per car, handed out one at a time
   in round-robin order on a valid/ready stream; a pending report holds its car. */
module arrival_event_queue (
    input  logic                              clk,
    input  logic                              rst,
    input  elev_types_pkg::car_status_t       status [elev_cfg_pkg::NUM_CARS],
    output elev_types_pkg::arrival_event_t    event_data,
    output logic                              event_valid,
    input  logic                              event_ready,
    output logic [elev_cfg_pkg::NUM_CARS-1:0] hold
);

    logic [elev_cfg_pkg::NUM_CARS-1:0] pending;
    logic [elev_cfg_pkg::NUM_CARS-1:0] arrived;
    elev_types_pkg::arrival_event_t    slot [elev_cfg_pkg::NUM_CARS];
    logic [elev_cfg_pkg::CAR_W-1:0]    rr_ptr;
    logic [elev_cfg_pkg::CAR_W-1:0]    sel;
    logic                              take;

    // First pending car at or after the pointer.
    // Scanned backwards so the nearest one wins.
    always_comb begin
        int idx;
        sel = rr_ptr;
        for (int i = elev_cfg_pkg::NUM_CARS - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % elev_cfg_pkg::NUM_CARS;
            if (pending[idx]) begin
                sel = idx[elev_cfg_pkg::CAR_W-1:0];
            end
        end
        for (int c = 0; c < elev_cfg_pkg::NUM_CARS; c++) begin
            arrived[c] = status[c].arrived;
        end
    end

    assign event_data = slot[sel];
    assign event_valid = |pending;
    assign hold = pending;
    assign take = event_valid && event_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            rr_ptr <= '0;
        end else begin
            if (take) begin
                pending[sel] <= 1'b0;
                rr_ptr <= (sel == elev_cfg_pkg::NUM_CARS - 1) ? '0 : sel + 1'b1;
            end else if (event_valid) begin
                // Park on the presented car so the payload stays put.
                rr_ptr <= sel;
            end
            for (int c = 0; c < elev_cfg_pkg::NUM_CARS; c++) begin
                if (arrived[c]) begin
                    pending[c] <= 1'b1;
                end
            end
        end
    end

    // Report payload, captured on the arrival pulse.
    always_ff @(posedge clk) begin
        for (int c = 0; c < elev_cfg_pkg::NUM_CARS; c++) begin
            if (arrived[c]) begin
                slot[c] <= '{car: c[elev_cfg_pkg::CAR_W-1:0],
                             floor: status[c].floor, dir: status[c].dir};
            end
        end
    end

    // Hold in the car must keep it from arriving again before its report drains.
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        (arrived & pending) == '0);

endmodule

// File: verilog/elevator_bank.sv
/* Top level of the elevator bank. Ties the hall-call controller, one car per
   generate step and the arrival queue to the three outside streams. */
module elevator_bank (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  elev_types_pkg::hall_call_t                                  hall_call,
    input  logic                                                        hall_valid,
    output logic                                                        hall_ready,
    input  elev_types_pkg::car_call_t                                   car_call,
    input  logic                                                        car_valid,
    output logic                                                        car_ready,
    output elev_types_pkg::arrival_event_t                              event_data,
    output logic                                                        event_valid,
    input  logic                                                        event_ready,
    output logic [1:0][elev_cfg_pkg::NUM_FLOORS-1:0]                    hall_lamps,
    output logic [elev_cfg_pkg::NUM_CARS-1:0][elev_cfg_pkg::NUM_FLOORS-1:0] car_lamps,
    output elev_types_pkg::car_status_t status [elev_cfg_pkg::NUM_CARS]
);

    elev_types_pkg::car_cmd_t          cmd [elev_cfg_pkg::NUM_CARS];
    logic [elev_cfg_pkg::NUM_CARS-1:0] hold;

    // Cab buttons are flags in each car and never stall.
    assign car_ready = 1'b1;

    hall_call_dispatch u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .hall_call  (hall_call),
        .hall_valid (hall_valid),
        .hall_ready (hall_ready),
        .status     (status),
        .cmd        (cmd),
        .hall_lamps (hall_lamps)
    );

    // Every car sees the cab call stream and keeps its own presses.
    for (genvar i = 0; i < elev_cfg_pkg::NUM_CARS; i++) begin : g_car
        localparam logic [elev_cfg_pkg::CAR_W-1:0] car_id = i;

        elevator_car #(
            .car_id (car_id)
        ) u_car (
            .clk       (clk),
            .rst       (rst),
            .car_call  (car_call),
            .car_valid (car_valid),
            .cmd       (cmd[i]),
            .hold      (hold[i]),
            .status    (status[i]),
            .lamps     (car_lamps[i])
        );
    end

    arrival_event_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .status      (status),
        .event_data  (event_data),
        .event_valid (event_valid),
        .event_ready (event_ready),
        .hold        (hold)
    );

endmodule

// File: test/tb_elevator_bank.sv
/* Testbench for the elevator bank. Drives hall and cab calls on the falling edge,
   checks every arrival report against a floor-chain model, one line per test. */
module tb_elevator_bank;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    // Five tests of a few hundred cycles each; the random one is the longest.
    localparam int MAX_CYCLES = 4000;
    // Longest wait for the bank to settle after the last call of a step.
    localparam int IDLE_LIMIT = 500;

    logic clk;
    logic rst;
    elev_types_pkg::hall_call_t hall_call;
    logic hall_valid;
    logic hall_ready;
    elev_types_pkg::car_call_t car_call;
    logic car_valid;
    logic car_ready;
    elev_types_pkg::arrival_event_t event_data;
    logic event_valid;
    logic event_ready;
    logic [1:0][elev_cfg_pkg::NUM_FLOORS-1:0] hall_lamps;
    logic [elev_cfg_pkg::NUM_CARS-1:0][elev_cfg_pkg::NUM_FLOORS-1:0] car_lamps;
    elev_types_pkg::car_status_t status [elev_cfg_pkg::NUM_CARS];

    int errors = 0;
    int failed_tests = 0;
    int test_errors = 0;
    int cycles = 0;
    string test_name = "reset";
    // Last reported floor of each car; every car starts at floor 0.
    int last_floor [elev_cfg_pkg::NUM_CARS] = '{default: 0};
    // Reports seen since the current test cleared the log.
    elev_types_pkg::arrival_event_t events [$];
    logic [31:0] rng_state = 32'hb6a7;

    elevator_bank UUT (
        .clk         (clk),
        .rst         (rst),
        .hall_call   (hall_call),
        .hall_valid  (hall_valid),
        .hall_ready  (hall_ready),
        .car_call    (car_call),
        .car_valid   (car_valid),
        .car_ready   (car_ready),
        .event_data  (event_data),
        .event_valid (event_valid),
        .event_ready (event_ready),
        .hall_lamps  (hall_lamps),
        .car_lamps   (car_lamps),
        .status      (status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ********************
    // Models and helpers.
    // ********************

    // Adjacent floor along dir; a step past an end floor gives an impossible floor.
    function automatic int expected_floor(input int prev, input elev_types_pkg::dir_t dir);
        if (dir == elev_types_pkg::UP) begin
            return prev + 1;
        end
        return prev - 1;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // All lamps dark, cars parked with doors closed, no report in flight.
    function automatic bit bank_idle();
        bit idle;
        idle = (hall_lamps == '0) && (car_lamps == '0) && !event_valid;
        for (int c = 0; c < elev_cfg_pkg::NUM_CARS; c++) begin
            if (status[c].motion != elev_types_pkg::STOPPED ||
                status[c].door != elev_types_pkg::CLOSED || status[c].arrived) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    task automatic flag_error(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
        events.delete();
    endtask

    task automatic close_test(input int num);
        if (errors == test_errors) begin
            $display("Test %0d (%s) passed", num, test_name);
        end else begin
            $display("Test %0d (%s) failed with %0d errors", num, test_name,
                     errors - test_errors);
            failed_tests++;
        end
    endtask

    task automatic send_hall(input logic [elev_cfg_pkg::FLOOR_W-1:0] floor,
                             input elev_types_pkg::dir_t dir);
        hall_call.floor = floor;
        hall_call.dir = dir;
        hall_valid = 1'b1;
        @(posedge clk);
        while (!hall_ready) @(posedge clk);
        @(negedge clk);
        hall_valid = 1'b0;
    endtask

    task automatic send_car(input logic [elev_cfg_pkg::CAR_W-1:0] car,
                            input logic [elev_cfg_pkg::FLOOR_W-1:0] floor);
        car_call.car = car;
        car_call.floor = floor;
        car_valid = 1'b1;
        @(posedge clk);
        while (!car_ready) @(posedge clk);
        @(negedge clk);
        car_valid = 1'b0;
    endtask

    // Every call must be served, so a bank that never settles is an error.
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (!bank_idle() && n < IDLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bank_idle()) begin
            flag_error($sformatf("bank still busy %0d cycles after the last call",
                                 IDLE_LIMIT));
        end
    endtask

    // ********************
    // Report checker.
    // ********************

    // Each transfer must continue its car's floor chain by one floor.
    always @(posedge clk) begin
        int exp;
        if (!rst && event_valid && event_ready) begin
            exp = expected_floor(last_floor[event_data.car], event_data.dir);
            if (int'(event_data.floor) != exp) begin
                flag_error($sformatf("car %0d reported floor %0d, expected %0d",
                                     event_data.car, event_data.floor, exp));
            end
            last_floor[event_data.car] = event_data.floor;
            events.push_back(event_data);
        end
    end

    // Ends a run that stops making progress.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: test %s did not finish within %0d cycles", test_name,
                     MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ********************
    // Stimulus.
    // ********************
    initial begin
        logic [elev_cfg_pkg::FLOOR_W-1:0] target;
        logic [31:0] r;
        elev_types_pkg::dir_t d;
        int start_floor;
        int halt_floor;
        int count;
        bit moved;

        clk = 1'b0;
        rst = 1'b1;
        hall_call = '0;
        hall_valid = 1'b0;
        car_call = '0;
        car_valid = 1'b0;
        event_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset state");
        for (int c = 0; c < elev_cfg_pkg::NUM_CARS; c++) begin
            if (status[c] != elev_types_pkg::car_status_t'{
                    floor: 0, dir: elev_types_pkg::UP,
                    motion: elev_types_pkg::STOPPED,
                    door: elev_types_pkg::CLOSED, arrived: 1'b0}) begin
                flag_error($sformatf("car %0d status %h after reset", c, status[c]));
            end
        end
        if (hall_lamps != '0 || car_lamps != '0 || event_valid) begin
            flag_error("lamps or event_valid set after reset");
        end
        // Both call inputs take a press in every cycle.
        if (!hall_ready || !car_ready) begin
            flag_error("hall_ready or car_ready low after reset");
        end
        close_test(1);

        start_test("cab call to top floor");
        send_car(0, 3);
        if (!car_lamps[0][3]) begin
            flag_error("cab lamp 3 of car 0 not lit after the call");
        end
        while (events.size() < 3) @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            if (events[i].car != 0 || events[i].floor != i + 1 ||
                events[i].dir != elev_types_pkg::UP) begin
                flag_error($sformatf("report %0d is %h, expected car 0 floor %0d UP",
                                     i, events[i], i + 1));
            end
        end
        while (status[0].door != elev_types_pkg::OPENING) @(negedge clk);
        if (car_lamps[0][3]) begin
            flag_error("cab lamp 3 of car 0 still lit with the door opening");
        end
        while (status[0].door != elev_types_pkg::OPEN) @(negedge clk);
        wait_idle();
        close_test(2);

        start_test("hall call down at floor 2");
        // Bring car 0 back to the ground floor so both cars start below the call.
        send_car(0, 0);
        wait_idle();
        events.delete();
        send_hall(2, elev_types_pkg::DOWN);
        if (!hall_lamps[elev_types_pkg::DOWN][2]) begin
            flag_error("hall lamp DOWN 2 not lit after the call");
        end
        while (hall_lamps[elev_types_pkg::DOWN][2]) @(negedge clk);
        wait_idle();
        count = 0;
        foreach (events[i]) begin
            if (events[i].floor == 2) begin
                count++;
            end
        end
        if (count == 0) begin
            flag_error("no car reported an arrival at floor 2");
        end
        close_test(3);

        start_test("back-pressure");
        event_ready = 1'b0;
        start_floor = status[1].floor;
        target = (start_floor < 2) ? 2'd3 : 2'd0;
        send_car(1, target);
        while (!event_valid) @(negedge clk);
        halt_floor = status[1].floor;
        moved = 1'b0;
        // Several travel times with the report stuck.
        repeat (4 * elev_cfg_pkg::TRAVEL_CYCLES) begin
            @(negedge clk);
            if (status[1].motion != elev_types_pkg::STOPPED ||
                status[1].floor != halt_floor || !event_valid) begin
                moved = 1'b1;
            end
        end
        if (moved) begin
            flag_error("car 1 left its floor while its report was pending");
        end
        event_ready = 1'b1;
        wait_idle();
        count = 0;
        foreach (events[i]) begin
            if (events[i].car == 1) begin
                count++;
            end
        end
        if (count != ((target > start_floor) ? target - start_floor : start_floor - target)) begin
            flag_error($sformatf("car 1 gave %0d reports from %0d to %0d",
                                 count, start_floor, target));
        end
        close_test(4);

        start_test("random calls");
        for (int n = 0; n < 30; n++) begin
            rng_state = xorshift(rng_state);
            r = rng_state;
            if (r[0]) begin
                // Only buttons that exist on a real floor panel.
                if (r[3:2] == 0) begin
                    d = elev_types_pkg::UP;
                end else if (r[3:2] == elev_cfg_pkg::TOP_FLOOR) begin
                    d = elev_types_pkg::DOWN;
                end else begin
                    d = elev_types_pkg::dir_t'(r[4]);
                end
                send_hall(r[3:2], d);
            end else begin
                send_car(r[5], r[3:2]);
            end
            repeat (r[8:6]) @(negedge clk);
        end
        wait_idle();
        close_test(5);

        $display("Tests run: 5, failed: %0d, errors: %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
verilog/elev_cfg_pkg.sv
verilog/elev_types_pkg.sv
verilog/hall_call_dispatch.sv
verilog/elevator_car.sv
verilog/arrival_event_queue.sv
verilog/elevator_bank.sv
test/tb_elevator_bank.sv
